/* files.f */
src/isa_pkg.sv
src/pipe_pkg.sv
src/stage_if.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/mips_core.sv
sim/mips_core_asserts.sv
sim/mips_core_tb.sv

/* sim/mips_core_cases.txt */
# P byte_addr word (hex) | E reg (decimal) value (hex)
# N retire count (decimal) | R run the case
# ALU, immediates and a write to register 0
P 00 24010005
P 04 2402fffd
P 08 3c031234
P 0c 24040ff6
P 10 00222821
P 14 00223023
P 18 00443824
P 1c 00614025
P 20 0041482a
P 24 0022502a
P 28 24200007
P 2c 240b8000
P 30 03e00008
E 0 00000000
E 1 00000005
E 2 fffffffd
E 3 12340000
E 4 00000ff6
E 5 00000002
E 6 00000008
E 7 00000ff4
E 8 12340005
E 9 00000001
E 10 00000000
E 11 ffff8000
N 11
R
# Back-to-back read-after-write chain
P 00 24010001
P 04 24210002
P 08 00211021
P 0c 00411823
P 10 00622021
P 14 0064282a
P 18 24a50064
P 1c 3c0600ab
P 20 00c53025
P 24 03e00008
E 1 00000003
E 2 00000006
E 3 00000003
E 4 00000009
E 5 00000065
E 6 00ab0065
N 9
R
# Stores and loads, same and different words
P 00 24010040
P 04 3c02cafe
P 08 24421234
P 0c ac220000
P 10 24030077
P 14 ac230004
P 18 8c240000
P 1c 8c250004
P 20 ac250008
P 24 8c260008
P 28 00863821
P 2c 03e00008
E 1 00000040
E 2 cafe1234
E 3 00000077
E 4 cafe1234
E 5 00000077
E 6 00000077
E 7 cafe12ab
N 8
R
# BNE loop, BEQ not taken, BEQ taken over two words
P 00 24010003
P 04 24020000
P 08 24030003
P 0c 24050055
P 10 24060066
P 14 24420005
P 18 2421ffff
P 1c 1420fffd
P 20 10430002
P 24 24040011
P 28 10200002
P 2c 24050022
P 30 24060033
P 34 24070044
P 38 03e00008
E 1 00000000
E 2 0000000f
E 3 00000003
E 4 00000011
E 5 00000055
E 6 00000066
E 7 00000044
N 13
R
# Short program over stale memory words
P 00 24070123
P 04 00073823
P 08 03e00008
E 0 00000000
E 7 fffffedd
N 2
R

/* sim/mips_core_tb.sv */
/*
 * Runs the programs in sim/mips_core_cases.txt, opened relative to the
 * project root. Registers and data memory keep their contents across
 * cases, so each case writes every register above r0 that it checks.
 */
`timescale 1ns/1ps
`default_nettype none

module mips_core_tb;

    localparam string cases_path = "sim/mips_core_cases.txt";

    logic               clock;
    logic               rst;
    logic               load_en;
    logic [31:0]        load_addr;
    logic [31:0]        load_data;
    pipe_pkg::reg_idx_t dbg_reg;
    logic [31:0]        dbg_data;
    logic               retire_valid;
    pipe_pkg::reg_idx_t retire_rd;
    logic [31:0]        retire_data;
    logic               done;

    logic [31:0] prog_addr [$];
    logic [31:0] prog_word [$];
    logic [4:0]  exp_reg [$];
    logic [31:0] exp_val [$];
    logic [31:0] retired_val [32];
    bit          retired_seen [32];
    int          exp_count;
    int          cycle_count;
    int          cycle_limit;
    int          case_count;

    mips_core u_mips_core (
        .clock        (clock),
        .rst          (rst),
        .load_en      (load_en),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .dbg_reg      (dbg_reg),
        .dbg_data     (dbg_data),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .done         (done)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_problem(input string msg);
        $display("ERROR: %s", msg);
        abort_run();
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
        abort_run();
    endtask

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            report_problem($sformatf("timeout, done did not rise within %0d cycles",
                                     cycle_limit));
        end
        if (u_mips_core.u_asserts.failures != 0) begin
            report_problem("a bound assertion failed");
        end
    end

    // rst stays high for two rising edges
    task automatic pulse_reset();
        @(posedge clock);
        rst     <= 1'b1;
        load_en <= 1'b0;
        repeat (2) @(posedge clock);
        rst <= 1'b0;
    endtask

    // Starts on the edge that drops rst so fetch sees no idle cycle
    task automatic load_program();
        foreach (prog_addr[i]) begin
            load_en   <= 1'b1;
            load_addr <= prog_addr[i];
            load_data <= prog_word[i];
            @(posedge clock);
        end
        load_en <= 1'b0;
    endtask

    task automatic run_to_done(output int retires);
        retires = 0;
        foreach (retired_seen[r]) begin
            retired_seen[r] = 1'b0;
        end
        @(negedge clock);
        while (!done) begin
            if (retire_valid) begin
                assert (retire_rd != '0)
                    else report_problem("a retire was reported for register 0");
                retired_val[retire_rd]  = retire_data;
                retired_seen[retire_rd] = 1'b1;
                retires = retires + 1;
            end
            @(negedge clock);
        end
    endtask

    // Last retired value per register must match the final register value
    task automatic check_registers();
        foreach (exp_reg[i]) begin
            @(posedge clock);
            dbg_reg <= exp_reg[i];
            @(negedge clock);
            assert (dbg_data === exp_val[i])
                else report_mismatch($sformatf("dbg_data (r%0d)", exp_reg[i]),
                                     dbg_data, exp_val[i]);
            if (exp_reg[i] != '0) begin
                assert (retired_seen[exp_reg[i]])
                    else report_problem($sformatf("no retire was reported for r%0d",
                                                  exp_reg[i]));
                assert (retired_val[exp_reg[i]] === exp_val[i])
                    else report_mismatch($sformatf("retire_data (r%0d)", exp_reg[i]),
                                         retired_val[exp_reg[i]], exp_val[i]);
            end
        end
    endtask

    task automatic run_case();
        int retires;
        case_count = case_count + 1;
        pulse_reset();
        load_program();
        run_to_done(retires);
        assert (retires == exp_count)
            else report_mismatch("retire_valid count", retires, exp_count);
        check_registers();
        $display("case %0d: %0d retires, %0d registers checked",
                 case_count, retires, exp_reg.size());
        prog_addr.delete();
        prog_word.delete();
        exp_reg.delete();
        exp_val.delete();
        exp_count = 0;
    endtask

    // With execute low only the words and cases are counted
    task automatic read_cases(input bit execute, output int words, output int cases);
        int              fd;
        int              rc;
        logic [63:0]     tag;
        logic [31:0]     v1;
        logic [31:0]     v2;
        logic [8*256-1:0] rest;
        words = 0;
        cases = 0;
        fd = $fopen(cases_path, "r");
        if (fd == 0) begin
            report_problem("cannot open the cases file");
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "#") begin
                rc = $fgets(rest, fd);
            end else if (tag == "P") begin
                rc = $fscanf(fd, "%h %h", v1, v2);
                if (rc != 2) report_problem("a P record lacks its address or word");
                words = words + 1;
                if (execute) begin
                    prog_addr.push_back(v1);
                    prog_word.push_back(v2);
                end
            end else if (tag == "E") begin
                rc = $fscanf(fd, "%d %h", v1, v2);
                if (rc != 2) report_problem("an E record lacks its register or value");
                if (execute) begin
                    exp_reg.push_back(v1[4:0]);
                    exp_val.push_back(v2);
                end
            end else if (tag == "N") begin
                rc = $fscanf(fd, "%d", v1);
                if (rc != 1) report_problem("an N record lacks its count");
                exp_count = v1;
            end else if (tag == "R") begin
                cases = cases + 1;
                if (execute) run_case();
            end else begin
                report_problem("the cases file holds an unknown record");
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int words;
        int cases;
        rst         = 1'b1;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        dbg_reg     = '0;
        exp_count   = 0;
        cycle_count = 0;
        cycle_limit = 0;
        case_count  = 0;
        read_cases(1'b0, words, cases);
        if (cases == 0) report_problem("the cases file holds no case to run");
        cycle_limit = 20 * words + 50 * cases;
        read_cases(1'b1, words, cases);
        if (u_mips_core.u_asserts.failures == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("ERROR: %0d bound assertion failures",
                     u_mips_core.u_asserts.failures);
            $display("FAIL: see errors above");
            $fatal(1, "bound assertions failed");
        end
    end

endmodule

`default_nettype wire

/* sim/mips_core_asserts.sv */
/*
 * Concurrent checks on mips_core, bound into every instance.
 * Reaches the internal redirect net of the core.
 */
`timescale 1ns/1ps
`default_nettype none

module mips_core_asserts (
    input  logic clock,
    input  logic rst,
    input  logic done,
    input  logic retire_valid,
    input  logic redirect
);

    int failures = 0;

    // Nothing issues after the halt
    halt_stops_fetch: assert property (@(posedge clock) disable iff (rst)
        done |-> !redirect)
        else begin
            $error("redirect high while done is high");
            failures = failures + 1;
        end

    no_retire_after_done: assert property (@(posedge clock) disable iff (rst)
        !(retire_valid && done))
        else begin
            $error("retire_valid high while done is high");
            failures = failures + 1;
        end

    // A redirect flushes its successor, so it cannot repeat at once
    single_redirect: assert property (@(posedge clock) disable iff (rst)
        redirect |=> !redirect)
        else begin
            $error("redirect high for two cycles in a row");
            failures = failures + 1;
        end

endmodule

bind mips_core mips_core_asserts u_asserts (
    .clock        (clock),
    .rst          (rst),
    .done         (done),
    .retire_valid (retire_valid),
    .redirect     (redirect)
);

`default_nettype wire

/* src/mips_core.sv */
/*
 * Five-stage integer pipeline. Fill instruction memory through the load
 * port, drop load_en to run from address 0, and wait for done.
 * Assert rst between programs.
 */
`timescale 1ns/1ps
`default_nettype none

module mips_core #(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
) (
    input  logic                      clock,
    input  logic                      rst,
    input  logic                      load_en,
    input  logic [pipe_pkg::xlen-1:0] load_addr,
    input  logic [pipe_pkg::xlen-1:0] load_data,
    input  pipe_pkg::reg_idx_t        dbg_reg,
    output logic [pipe_pkg::xlen-1:0] dbg_data,
    output logic                      retire_valid,
    output pipe_pkg::reg_idx_t        retire_rd,
    output logic [pipe_pkg::xlen-1:0] retire_data,
    output logic                      done
);

    logic                      stall;
    logic                      redirect;
    logic [pipe_pkg::xlen-1:0] target;
    logic                      flush;
    logic                      halt_seen;
    logic                      wb_en;
    pipe_pkg::reg_idx_t        wb_rd;
    logic [pipe_pkg::xlen-1:0] wb_data;
    pipe_pkg::reg_idx_t        ex_rd;
    logic                      ex_wr;
    pipe_pkg::reg_idx_t        mem_rd_idx;
    logic                      mem_wr_flag;

    stage_link link_fd ();
    stage_link link_de ();
    stage_link link_em ();

    fetch_stage #(
        .IMEM_WORDS (IMEM_WORDS)
    ) u_fetch (
        .clock     (clock),
        .rst       (rst),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .stall     (stall),
        .redirect  (redirect),
        .target    (target),
        .halt_seen (halt_seen),
        .out       (link_fd.src)
    );

    decode_stage u_decode (
        .clock       (clock),
        .rst         (rst),
        .in          (link_fd.dst),
        .out         (link_de.src),
        .flush       (flush),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .ex_rd       (ex_rd),
        .ex_wr       (ex_wr),
        .mem_rd_idx  (mem_rd_idx),
        .mem_wr_flag (mem_wr_flag),
        .stall       (stall),
        .dbg_reg     (dbg_reg),
        .dbg_data    (dbg_data)
    );

    execute_stage u_execute (
        .clock     (clock),
        .rst       (rst),
        .in        (link_de.dst),
        .out       (link_em.src),
        .redirect  (redirect),
        .target    (target),
        .flush     (flush),
        .halt_seen (halt_seen),
        .ex_rd     (ex_rd),
        .ex_wr     (ex_wr)
    );

    memory_stage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_memory (
        .clock        (clock),
        .rst          (rst),
        .in           (link_em.dst),
        .wb_en        (wb_en),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .mem_rd_idx   (mem_rd_idx),
        .mem_wr_flag  (mem_wr_flag),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .done         (done)
    );

endmodule

`default_nettype wire

/* src/memory_stage.sv */
/*
 * Word-only data memory and write-back register. DMEM_WORDS must be a
 * power of two, at least 2; addresses wrap. Memory is not cleared.
 */
`timescale 1ns/1ps
`default_nettype none

module memory_stage #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                      clock,
    input  logic                      rst,
    stage_link.dst                    in,
    output logic                      wb_en,
    output pipe_pkg::reg_idx_t        wb_rd,
    output logic [pipe_pkg::xlen-1:0] wb_data,
    output pipe_pkg::reg_idx_t        mem_rd_idx,
    output logic                      mem_wr_flag,
    output logic                      retire_valid,
    output pipe_pkg::reg_idx_t        retire_rd,
    output logic [pipe_pkg::xlen-1:0] retire_data,
    output logic                      done
);

    localparam int daw = $clog2(DMEM_WORDS);

    logic [pipe_pkg::xlen-1:0] dmem [DMEM_WORDS];
    logic [daw-1:0]            idx;
    logic                      is_halt;

    assign idx     = in.a[daw+1:2];
    assign is_halt = (in.insn.r.opcode == isa_pkg::op_rtype) &&
                     (in.insn.r.funct == isa_pkg::fn_jr) &&
                     (in.insn.r.rs == pipe_pkg::ra_index);

    always_ff @(posedge clock) begin
        if (in.valid && in.mem_wr) begin
            dmem[idx] <= in.b;
        end
        wb_data <= in.mem_rd ? dmem[idx] : in.a;
        wb_rd   <= in.rd;
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            wb_en <= 1'b0;
            done  <= 1'b0;
        end else begin
            wb_en <= in.valid && in.wr && (in.rd != '0);
            if (in.valid && is_halt) begin
                done <= 1'b1;
            end
        end
    end

    assign mem_rd_idx   = in.rd;
    assign mem_wr_flag  = in.valid && in.wr;
    assign retire_valid = wb_en;
    assign retire_rd    = wb_rd;
    assign retire_data  = wb_data;

endmodule

`default_nettype wire

/* src/execute_stage.sv */
/*
 * ALU, branch resolution and halt detection. Branches and JR resolve
 * here, no delay slot. JR through r31 halts; the JR moves on as a
 * non-writing marker.
 */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                      clock,
    input  logic                      rst,
    stage_link.dst                    in,
    stage_link.src                    out,
    output logic                      redirect,
    output logic [pipe_pkg::xlen-1:0] target,
    output logic                      flush,
    output logic                      halt_seen,
    output pipe_pkg::reg_idx_t        ex_rd,
    output logic                      ex_wr
);

    logic [pipe_pkg::xlen-1:0] imm_sext;
    logic [pipe_pkg::xlen-1:0] b_op;
    logic [pipe_pkg::xlen-1:0] result;
    logic                      is_jr;
    logic                      taken;
    logic                      halt_q;

    assign imm_sext = {{16{in.insn.i.imm16[15]}}, in.insn.i.imm16};
    // Stores keep rt data in b, so the offset comes from the word
    assign b_op     = in.mem_wr ? imm_sext : in.b;

    always_comb begin
        case (in.op)
            pipe_pkg::alu_sub: result = in.a - b_op;
            pipe_pkg::alu_and: result = in.a & b_op;
            pipe_pkg::alu_or:  result = in.a | b_op;
            pipe_pkg::alu_slt: result = {31'b0, $signed(in.a) < $signed(b_op)};
            pipe_pkg::alu_lui: result = {b_op[15:0], 16'h0};
            default:           result = in.a + b_op;
        endcase
    end

    assign is_jr = (in.insn.r.opcode == isa_pkg::op_rtype) && (in.insn.r.funct == isa_pkg::fn_jr);
    assign taken = ((in.insn.i.opcode == isa_pkg::op_beq) && (in.a == in.b)) ||
                   ((in.insn.i.opcode == isa_pkg::op_bne) && (in.a != in.b));

    assign redirect = in.valid && (taken || is_jr);
    assign flush    = redirect;
    assign target   = is_jr ? in.a : in.pc + 32'd4 + {imm_sext[29:0], 2'b00};

    always_ff @(posedge clock) begin
        if (rst) begin
            halt_q <= 1'b0;
        end else if (in.valid && is_jr && in.insn.r.rs == pipe_pkg::ra_index) begin
            halt_q <= 1'b1;
        end
    end

    assign halt_seen = halt_q;
    assign ex_rd     = in.rd;
    assign ex_wr     = in.valid && in.wr;

    always_ff @(posedge clock) begin
        if (rst) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= in.valid;
        end
    end

    always_ff @(posedge clock) begin
        out.insn   <= in.insn;
        out.pc     <= in.pc;
        out.a      <= result;
        out.b      <= in.b;
        out.rd     <= in.rd;
        out.wr     <= in.wr;
        out.mem_rd <= in.mem_rd;
        out.mem_wr <= in.mem_wr;
        out.op     <= in.op;
    end

endmodule

`default_nettype wire

/* src/decode_stage.sv */
/*
 * Register file, control decode and interlock. No forwarding: a source
 * waits until its producer reaches write-back, where a write-first read
 * picks up the new value. Unknown opcodes decode as no-ops.
 */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                      clock,
    input  logic                      rst,
    stage_link.dst                    in,
    stage_link.src                    out,
    input  logic                      flush,
    input  logic                      wb_en,
    input  pipe_pkg::reg_idx_t        wb_rd,
    input  logic [pipe_pkg::xlen-1:0] wb_data,
    input  pipe_pkg::reg_idx_t        ex_rd,
    input  logic                      ex_wr,
    input  pipe_pkg::reg_idx_t        mem_rd_idx,
    input  logic                      mem_wr_flag,
    output logic                      stall,
    input  pipe_pkg::reg_idx_t        dbg_reg,
    output logic [pipe_pkg::xlen-1:0] dbg_data
);

    logic [pipe_pkg::xlen-1:0] regs [32];
    pipe_pkg::reg_idx_t        rs;
    pipe_pkg::reg_idx_t        rt;
    logic [pipe_pkg::xlen-1:0] rs_val;
    logic [pipe_pkg::xlen-1:0] rt_val;
    logic [pipe_pkg::xlen-1:0] imm_ext;
    logic                      use_rs;
    logic                      use_rt;
    logic                      use_imm;
    logic                      rt_dest;
    logic                      dec_wr;
    logic                      dec_mem_rd;
    logic                      dec_mem_wr;
    pipe_pkg::alu_op_t         dec_op;
    logic                      hazard_rs;
    logic                      hazard_rt;

    assign rs = in.insn.r.rs;
    assign rt = in.insn.r.rt;

    // wb_en is already low for register 0
    always_ff @(posedge clock) begin
        if (wb_en) begin
            regs[wb_rd] <= wb_data;
        end
    end

    assign rs_val   = (rs == '0) ? '0 : (wb_en && wb_rd == rs) ? wb_data : regs[rs];
    assign rt_val   = (rt == '0) ? '0 : (wb_en && wb_rd == rt) ? wb_data : regs[rt];
    assign dbg_data = (dbg_reg == '0) ? '0 : regs[dbg_reg];

    always_comb begin
        dec_op     = pipe_pkg::alu_add;
        use_rs     = 1'b1;
        use_rt     = 1'b0;
        use_imm    = 1'b1;
        rt_dest    = 1'b1;
        dec_wr     = 1'b0;
        dec_mem_rd = 1'b0;
        dec_mem_wr = 1'b0;
        imm_ext    = {{16{in.insn.i.imm16[15]}}, in.insn.i.imm16};
        case (in.insn.i.opcode)
            isa_pkg::op_rtype: begin
                use_rt  = 1'b1;
                use_imm = 1'b0;
                rt_dest = 1'b0;
                dec_wr  = 1'b1;
                case (in.insn.r.funct)
                    isa_pkg::fn_addu: dec_op = pipe_pkg::alu_add;
                    isa_pkg::fn_subu: dec_op = pipe_pkg::alu_sub;
                    isa_pkg::fn_and:  dec_op = pipe_pkg::alu_and;
                    isa_pkg::fn_or:   dec_op = pipe_pkg::alu_or;
                    isa_pkg::fn_slt:  dec_op = pipe_pkg::alu_slt;
                    isa_pkg::fn_jr: begin
                        use_rt = 1'b0;
                        dec_wr = 1'b0;
                    end
                    default: begin
                        use_rs = 1'b0;
                        use_rt = 1'b0;
                        dec_wr = 1'b0;
                    end
                endcase
            end
            isa_pkg::op_addiu: dec_wr = 1'b1;
            isa_pkg::op_lui: begin
                use_rs  = 1'b0;
                dec_op  = pipe_pkg::alu_lui;
                dec_wr  = 1'b1;
                imm_ext = {16'h0, in.insn.i.imm16};
            end
            isa_pkg::op_lw: begin
                dec_wr     = 1'b1;
                dec_mem_rd = 1'b1;
            end
            // Store data rides in b, execute adds the offset
            isa_pkg::op_sw: begin
                use_rt     = 1'b1;
                use_imm    = 1'b0;
                dec_mem_wr = 1'b1;
            end
            isa_pkg::op_beq, isa_pkg::op_bne: begin
                use_rt  = 1'b1;
                use_imm = 1'b0;
                dec_op  = pipe_pkg::alu_sub;
            end
            default: use_rs = 1'b0;
        endcase
    end

    assign hazard_rs = (rs != '0) && ((ex_wr && rs == ex_rd) || (mem_wr_flag && rs == mem_rd_idx));
    assign hazard_rt = (rt != '0) && ((ex_wr && rt == ex_rd) || (mem_wr_flag && rt == mem_rd_idx));
    assign stall     = in.valid && ((use_rs && hazard_rs) || (use_rt && hazard_rt));

    always_ff @(posedge clock) begin
        if (rst || flush) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= in.valid && !stall;
        end
    end

    always_ff @(posedge clock) begin
        out.insn   <= stall ? isa_pkg::nop_word : in.insn;
        out.pc     <= in.pc;
        out.a      <= rs_val;
        out.b      <= use_imm ? imm_ext : rt_val;
        out.rd     <= rt_dest ? rt : in.insn.r.rd;
        out.wr     <= dec_wr;
        out.mem_rd <= dec_mem_rd;
        out.mem_wr <= dec_mem_wr;
        out.op     <= dec_op;
    end

endmodule

`default_nettype wire

/* src/fetch_stage.sv */
/*
 * PC and instruction memory. load_addr is a byte address, word aligned.
 * IMEM_WORDS must be a power of two, at least 2. Nothing issues while
 * load_en is high or after a halt until rst.
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
    parameter int IMEM_WORDS = 256
) (
    input  logic                      clock,
    input  logic                      rst,
    input  logic                      load_en,
    input  logic [pipe_pkg::xlen-1:0] load_addr,
    input  logic [pipe_pkg::xlen-1:0] load_data,
    input  logic                      stall,
    input  logic                      redirect,
    input  logic [pipe_pkg::xlen-1:0] target,
    input  logic                      halt_seen,
    stage_link.src                    out
);

    localparam int iaw = $clog2(IMEM_WORDS);

    logic [pipe_pkg::xlen-1:0] imem [IMEM_WORDS];
    logic [pipe_pkg::xlen-1:0] pc;

    always_ff @(posedge clock) begin
        if (load_en) begin
            imem[load_addr[iaw+1:2]] <= load_data;
        end
    end

    // Registered read doubles as the fetch/decode register
    always_ff @(posedge clock) begin
        if (!stall) begin
            out.insn <= imem[pc[iaw+1:2]];
            out.pc   <= pc;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            pc        <= '0;
            out.valid <= 1'b0;
        end else if (redirect) begin
            pc        <= target;
            out.valid <= 1'b0;
        end else if (load_en || halt_seen) begin
            out.valid <= 1'b0;
        end else if (!stall) begin
            pc        <= pc + 32'd4;
            out.valid <= 1'b1;
        end
    end

    // Decode builds these itself
    assign out.a      = '0;
    assign out.b      = '0;
    assign out.rd     = '0;
    assign out.wr     = 1'b0;
    assign out.mem_rd = 1'b0;
    assign out.mem_wr = 1'b0;
    assign out.op     = pipe_pkg::alu_add;

endmodule

`default_nettype wire

/* src/stage_if.sv */
/*
 * One instruction slot between two pipeline stages.
 * No handshake; valid qualifies the rest for a single cycle.
 */
`timescale 1ns/1ps
`default_nettype none

interface stage_link;

    logic                      valid;
    isa_pkg::insn_word_u       insn;
    logic [pipe_pkg::xlen-1:0] pc;
    // Operand or ALU result
    logic [pipe_pkg::xlen-1:0] a;
    // Operand or store data
    logic [pipe_pkg::xlen-1:0] b;
    pipe_pkg::reg_idx_t        rd;
    logic                      wr;
    logic                      mem_rd;
    logic                      mem_wr;
    pipe_pkg::alu_op_t         op;

    modport src (
        output valid, insn, pc, a, b, rd, wr, mem_rd, mem_wr, op
    );

    modport dst (
        input valid, insn, pc, a, b, rd, wr, mem_rd, mem_wr, op
    );

endinterface

`default_nettype wire

/* src/pipe_pkg.sv */
/*
 * Pipeline-wide widths and codes shared by all stages.
 */
`default_nettype none

package pipe_pkg;

    localparam int xlen = 32;

    typedef logic [4:0] reg_idx_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt,
        alu_lui
    } alu_op_t;

    // JR through this register halts the core
    localparam reg_idx_t ra_index = 5'd31;

endpackage

`default_nettype wire

/* src/isa_pkg.sv */
/*
 * MIPS-style instruction encodings for the integer subset only.
 * No byte, halfword, multiply, divide or exception encodings.
 */
`default_nettype none

package isa_pkg;

    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_beq   = 6'h04;
    localparam logic [5:0] op_bne   = 6'h05;
    localparam logic [5:0] op_addiu = 6'h09;
    localparam logic [5:0] op_lui   = 6'h0f;
    localparam logic [5:0] op_lw    = 6'h23;
    localparam logic [5:0] op_sw    = 6'h2b;

    localparam logic [5:0] fn_jr    = 6'h08;
    localparam logic [5:0] fn_addu  = 6'h21;
    localparam logic [5:0] fn_subu  = 6'h23;
    localparam logic [5:0] fn_and   = 6'h24;
    localparam logic [5:0] fn_or    = 6'h25;
    localparam logic [5:0] fn_slt   = 6'h2a;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_fmt_t;

    // Same 32 bits, register or immediate layout
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } insn_word_u;

    localparam insn_word_u nop_word = '0;

endpackage

`default_nettype wire
